// ==== test/id_trace.txt ====
# stall pc inst rf1 rf2 | ex: wreg wd data | mem: wreg wd data | exp: ra1 ra2
# aluop alusel reg1 reg2 wd wreg link dslot reserved flag target (all hex)
0 00400000 34228001 0000f0f0 deadbeef 0 00 00000000 0 00 00000000 01 02 01 1 0000f0f0 00008001 02 1 00000000 0 0 0 00000000
0 00400004 3083ffff 12345678 00000000 0 00 00000000 0 00 00000000 04 03 02 1 12345678 0000ffff 03 1 00000000 0 0 0 00000000
0 00400008 38c500aa 000000ff 00000000 0 00 00000000 0 00 00000000 06 05 03 1 000000ff 000000aa 05 1 00000000 0 0 0 00000000
0 0040000c 3c07abcd 00000000 00000000 0 00 00000000 0 00 00000000 00 07 01 1 00000000 abcd0000 07 1 00000000 0 0 0 00000000
0 00400010 2128fffc 00000010 00000000 0 00 00000000 0 00 00000000 09 08 0a 3 00000010 fffffffc 08 1 00000000 0 0 0 00000000
0 00400014 256a7fff 00000001 00000000 0 00 00000000 0 00 00000000 0b 0a 0b 3 00000001 00007fff 0a 1 00000000 0 0 0 00000000
0 00400018 29ac8000 80000000 00000000 0 00 00000000 0 00 00000000 0d 0c 0e 3 80000000 ffff8000 0c 1 00000000 0 0 0 00000000
0 0040001c 2dee0005 00000003 00000000 0 00 00000000 0 00 00000000 0f 0e 0f 3 00000003 00000005 0e 1 00000000 0 0 0 00000000
0 00400020 00221821 00000005 00000007 0 00 00000000 0 00 00000000 01 02 09 3 00000005 00000007 03 1 00000000 0 0 0 00000000
0 00400024 000520c0 11111111 0000000f 0 00 00000000 0 00 00000000 00 05 05 2 00000003 0000000f 04 1 00000000 0 0 0 00000000
0 00400028 01073007 00000004 80000000 0 00 00000000 0 00 00000000 08 07 07 2 00000004 80000000 06 1 00000000 0 0 0 00000000
0 0040002c 014b4827 0f0f0f0f 00ff00ff 0 00 00000000 0 00 00000000 0a 0b 04 1 0f0f0f0f 00ff00ff 09 1 00000000 0 0 0 00000000
0 00400030 00221820 00000001 00000002 1 01 aaaaaaaa 1 01 bbbbbbbb 01 02 08 3 aaaaaaaa 00000002 03 1 00000000 0 0 0 00000000
0 00400034 00221822 00000001 00000002 1 05 cccccccc 1 02 dddddddd 01 02 0c 3 00000001 dddddddd 03 1 00000000 0 0 0 00000000
0 00400038 00221823 00000001 00000002 0 01 eeeeeeee 1 01 99999999 01 02 0d 3 99999999 00000002 03 1 00000000 0 0 0 00000000
0 0040003c 10220004 00000007 00000007 0 00 00000000 0 00 00000000 01 02 14 4 00000007 00000007 00 0 00000000 0 0 1 00400050
0 00400040 34220001 00000000 00000000 0 00 00000000 0 00 00000000 01 02 01 1 00000000 00000001 02 1 00000000 1 0 0 00000000
0 00400050 1422fffe 00000005 00000005 0 00 00000000 0 00 00000000 01 02 15 4 00000005 00000005 1f 0 00000000 0 0 0 00000000
0 00400054 24010010 00000000 00000000 0 00 00000000 0 00 00000000 00 01 0b 3 00000000 00000010 01 1 00000000 0 0 0 00000000
0 00400058 14220008 00000005 00000005 0 00 00000000 1 02 00000006 01 02 15 4 00000005 00000006 00 0 00000000 0 0 1 0040007c
1 0040005c 38830f0f 0000ffff 00000000 0 00 00000000 0 00 00000000 04 03 15 4 00000005 00000006 00 0 00000000 0 0 1 0040007c
1 0040005c 38830f0f 0000ffff 00000000 0 00 00000000 0 00 00000000 04 03 15 4 00000005 00000006 00 0 00000000 0 0 1 0040007c
0 0040005c 38830f0f 0000ffff 00000000 0 00 00000000 0 00 00000000 04 03 03 1 0000ffff 00000f0f 03 1 00000000 1 0 0 00000000
0 0040007c 1c200003 00000001 00000000 0 00 00000000 0 00 00000000 01 00 16 4 00000001 00000000 00 0 00000000 0 0 1 0040008c
0 00400080 1c200003 00000000 00000000 0 00 00000000 0 00 00000000 01 00 16 4 00000000 00000000 00 0 00000000 1 0 0 00000000
0 00400084 1820ffff 80000000 00000000 0 00 00000000 0 00 00000000 01 00 17 4 80000000 00000000 1f 0 00000000 0 0 1 00400084
0 00400088 1820ffff 00000000 00000000 0 00 00000000 0 00 00000000 01 00 17 4 00000000 00000000 1f 0 00000000 1 0 1 00400088
0 0040008c 1820ffff 00000001 00000000 0 00 00000000 0 00 00000000 01 00 17 4 00000001 00000000 1f 0 00000000 1 0 0 00000000
0 00400090 04210002 00000000 00000000 0 00 00000000 0 00 00000000 01 01 18 4 00000000 00000000 00 0 00000000 0 0 1 0040009c
0 00400094 04210002 ffffffff 00000000 0 00 00000000 0 00 00000000 01 01 18 4 ffffffff 00000000 00 0 00000000 1 0 0 00000000
0 00400098 04200002 fffffff0 00000000 0 00 00000000 0 00 00000000 01 00 1a 4 fffffff0 00000000 00 0 00000000 0 0 1 004000a4
0 0040009c 04200002 00000001 00000000 0 00 00000000 0 00 00000000 01 00 1a 4 00000001 00000000 00 0 00000000 1 0 0 00000000
0 004000a0 04310002 80000000 00000000 0 00 00000000 0 00 00000000 01 11 19 4 80000000 00000000 1f 1 004000a8 0 0 0 00000000
0 004000a4 04300002 80000000 00000000 0 00 00000000 0 00 00000000 01 10 1b 4 80000000 00000000 1f 1 004000ac 0 0 1 004000b0
0 004000a8 04300002 00000001 00000000 0 00 00000000 0 00 00000000 01 10 1b 4 00000001 00000000 1f 1 004000b0 1 0 0 00000000
0 004000ac 08100010 00000000 00000000 0 00 00000000 0 00 00000000 00 10 10 4 00000000 00000000 00 0 00000000 0 0 1 00400040
0 00400040 0c100020 00000000 00000000 0 00 00000000 0 00 00000000 00 10 11 4 00000000 00000000 1f 1 00400048 1 0 1 00400080
0 00400044 03e00008 00400048 00000000 0 00 00000000 0 00 00000000 1f 00 12 4 00400048 00000000 00 0 00000000 1 0 1 00400048
0 00400048 00802809 00401000 00000000 1 04 00402000 0 00 00000000 04 00 13 4 00402000 00000000 05 1 00400050 1 0 1 00402000
0 00402000 70221802 00000000 00000000 0 00 00000000 0 00 00000000 01 02 00 0 00000000 00000000 03 0 00000000 1 1 0 00000000
0 00402004 0000000f 00000000 00000000 0 00 00000000 0 00 00000000 00 00 00 0 00000000 00000000 00 0 00000000 0 1 0 00000000
0 00402008 34000000 00000000 00000000 0 00 00000000 0 00 00000000 00 00 01 1 00000000 00000000 00 1 00000000 0 0 0 00000000

// ==== build.f ====
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
verilog/id_stage.sv
test/tb_clock_gen.sv
test/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - verilog/id_pkg.sv
  - verilog/inst_decoder.sv
  - verilog/operand_forward.sv
  - verilog/branch_unit.sv
  - verilog/id_stage.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_id_stage.sv

// ==== test/tb_id_stage.sv ====
// tb_id_stage: trace-driven testbench for the MIPS32 decode stage
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
	import id_pkg::*;

	typedef struct packed {
		logic        stall;
		reg_bus_t    pc;
		reg_bus_t    inst;
		reg_bus_t    r1d;
		reg_bus_t    r2d;
		bypass_t     ex;
		bypass_t     mem;
		reg_addr_t   ra1;
		reg_addr_t   ra2;
		logic [5:0]  aluop;
		logic [2:0]  alusel;
		reg_bus_t    reg1;
		reg_bus_t    reg2;
		reg_addr_t   wd;
		logic        wreg;
		reg_bus_t    link;
		logic        dslot;
		logic        rsv;
		logic        flag;
		reg_bus_t    target;
	} trace_t;

	logic     clk;
	logic     reset_i;
	logic     stall_i;
	reg_bus_t pc_i;
	reg_bus_t inst_i;
	reg_bus_t reg1_data_i;
	reg_bus_t reg2_data_i;
	bypass_t  ex_bypass_i;
	bypass_t  mem_bypass_i;
	reg_addr_t reg1_addr_o;
	reg_addr_t reg2_addr_o;
	id_ex_t   id_ex_o;
	logic     branch_flag_o;
	reg_bus_t branch_target_o;

	trace_t vectors[$];
	// error groups: 0 address, 1 ID/EX, 2 branch, 3 trace file
	int     errors[4];
	int     cycles;
	int     cycle_limit;
	logic   trace_open;

	tb_clock_gen u_clock (
		.clk_o   (clk),
		.reset_o (reset_i)
	);

	id_stage DUT (
		.clk             (clk),
		.reset_i         (reset_i),
		.stall_i         (stall_i),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.reg1_data_i     (reg1_data_i),
		.reg2_data_i     (reg2_data_i),
		.ex_bypass_i     (ex_bypass_i),
		.mem_bypass_i    (mem_bypass_i),
		.reg1_addr_o     (reg1_addr_o),
		.reg2_addr_o     (reg2_addr_o),
		.id_ex_o         (id_ex_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o)
	);

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp, input int group);
		assert (got === exp)
			else begin
				$display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
				errors[group]++;
			end
	endtask

	task automatic print_error_counts();
		$display("errors: address %0d, id_ex %0d, branch %0d, trace %0d",
			errors[0], errors[1], errors[2], errors[3]);
	endtask

	task automatic load_trace();
		int          fd;
		int          n;
		int          line_no;
		string       line;
		logic [37:0] f [24];
		trace_t      t;
		fd = $fopen("test/id_trace.txt", "r");
		trace_open = (fd != 0);
		line_no = 0;
		if (trace_open) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				line_no++;
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
					f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22],
					f[23]);
				if (n != 24) begin
					$display("trace line %0d is malformed and was skipped", line_no);
					errors[3]++;
					continue;
				end
				t.stall     = f[0][0];
				t.pc        = f[1][31:0];
				t.inst      = f[2][31:0];
				t.r1d       = f[3][31:0];
				t.r2d       = f[4][31:0];
				t.ex        = '{wreg: f[5][0], wd: f[6][4:0], wdata: f[7][31:0]};
				t.mem       = '{wreg: f[8][0], wd: f[9][4:0], wdata: f[10][31:0]};
				t.ra1       = f[11][4:0];
				t.ra2       = f[12][4:0];
				t.aluop     = f[13][5:0];
				t.alusel    = f[14][2:0];
				t.reg1      = f[15][31:0];
				t.reg2      = f[16][31:0];
				t.wd        = f[17][4:0];
				t.wreg      = f[18][0];
				t.link      = f[19][31:0];
				t.dslot     = f[20][0];
				t.rsv       = f[21][0];
				t.flag      = f[22][0];
				t.target    = f[23][31:0];
				vectors.push_back(t);
			end
			$fclose(fd);
		end
	endtask

	task automatic drive(input trace_t t);
		stall_i      = t.stall;
		pc_i         = t.pc;
		inst_i       = t.inst;
		reg1_data_i  = t.r1d;
		reg2_data_i  = t.r2d;
		ex_bypass_i  = t.ex;
		mem_bypass_i = t.mem;
	endtask

	task automatic check_registered(input trace_t t);
		check_value("id_ex.aluop", 32'(id_ex_o.aluop), 32'(t.aluop), 1);
		check_value("id_ex.alusel", 32'(id_ex_o.alusel), 32'(t.alusel), 1);
		check_value("id_ex.reg1", id_ex_o.reg1, t.reg1, 1);
		check_value("id_ex.reg2", id_ex_o.reg2, t.reg2, 1);
		check_value("id_ex.wd", 32'(id_ex_o.wd), 32'(t.wd), 1);
		check_value("id_ex.wreg", 32'(id_ex_o.wreg), 32'(t.wreg), 1);
		check_value("id_ex.link_addr", id_ex_o.link_addr, t.link, 1);
		check_value("id_ex.is_in_delayslot", 32'(id_ex_o.is_in_delayslot), 32'(t.dslot), 1);
		check_value("id_ex.reserved", 32'(id_ex_o.reserved), 32'(t.rsv), 1);
		check_value("branch_flag", 32'(branch_flag_o), 32'(t.flag), 2);
		check_value("branch_target", branch_target_o, t.target, 2);
	endtask

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			print_error_counts();
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		stall_i      = 1'b0;
		pc_i         = '0;
		inst_i       = '0;
		reg1_data_i  = '0;
		reg2_data_i  = '0;
		ex_bypass_i  = '0;
		mem_bypass_i = '0;
		cycles       = 0;
		cycle_limit  = 0;
		load_trace();
		if (!trace_open) begin
			$display("could not open the trace file test/id_trace.txt");
			errors[3]++;
		end else if (vectors.size() == 0) begin
			$display("the trace file test/id_trace.txt holds no test vectors");
			errors[3]++;
		end else begin
			cycle_limit = vectors.size() + 20;
			@(negedge reset_i);
			// reset state
			check_value("id_ex after reset", 32'(id_ex_o != '0), 32'd0, 1);
			check_value("branch_flag after reset", 32'(branch_flag_o), 32'd0, 2);
			#1;
			foreach (vectors[i]) begin
				drive(vectors[i]);
				#3;
				check_value("reg1_addr", 32'(reg1_addr_o), 32'(vectors[i].ra1), 0);
				check_value("reg2_addr", 32'(reg2_addr_o), 32'(vectors[i].ra2), 0);
				@(posedge clk);
				#1;
				check_registered(vectors[i]);
			end
		end
		print_error_counts();
		if (errors[0] + errors[1] + errors[2] + errors[3] == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// tb_clock_gen: 8 ns testbench clock and a reset held high for the first two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
// id_stage: MIPS32 decode stage with operand bypass, branch resolve and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               stall_i,
	input  id_pkg::reg_bus_t   pc_i,
	input  id_pkg::reg_bus_t   inst_i,
	input  id_pkg::reg_bus_t   reg1_data_i,
	input  id_pkg::reg_bus_t   reg2_data_i,
	input  id_pkg::bypass_t    ex_bypass_i,
	input  id_pkg::bypass_t    mem_bypass_i,
	output id_pkg::reg_addr_t  reg1_addr_o,
	output id_pkg::reg_addr_t  reg2_addr_o,
	output id_pkg::id_ex_t     id_ex_o,
	output logic               branch_flag_o,
	output id_pkg::reg_bus_t   branch_target_o
);
	import id_pkg::*;

	decode_t  dec;
	reg_bus_t reg1;
	reg_bus_t reg2;
	reg_bus_t target;
	reg_bus_t link_addr;
	logic     taken;
	logic     in_delayslot_q;

	inst_decoder u_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	assign reg1_addr_o = dec.reg1_addr;
	assign reg2_addr_o = dec.reg2_addr;

	operand_forward u_fwd_reg1 (
		.read_i       (dec.reg1_read),
		.addr_i       (dec.reg1_addr),
		.rf_data_i    (reg1_data_i),
		.imm_i        (dec.imm),
		.ex_bypass_i  (ex_bypass_i),
		.mem_bypass_i (mem_bypass_i),
		.operand_o    (reg1)
	);

	operand_forward u_fwd_reg2 (
		.read_i       (dec.reg2_read),
		.addr_i       (dec.reg2_addr),
		.rf_data_i    (reg2_data_i),
		.imm_i        (dec.imm),
		.ex_bypass_i  (ex_bypass_i),
		.mem_bypass_i (mem_bypass_i),
		.operand_o    (reg2)
	);

	branch_unit u_branch (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.aluop_i     (dec.aluop),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.taken_o     (taken),
		.target_o    (target),
		.link_addr_o (link_addr)
	);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			id_ex_o         <= '0;
			branch_flag_o   <= 1'b0;
			branch_target_o <= '0;
			in_delayslot_q  <= 1'b0;
		end else if (!stall_i) begin
			id_ex_o.aluop           <= dec.aluop;
			id_ex_o.alusel          <= dec.alusel;
			id_ex_o.reg1            <= reg1;
			id_ex_o.reg2            <= reg2;
			id_ex_o.wd              <= dec.wd;
			id_ex_o.wreg            <= dec.wreg;
			id_ex_o.link_addr       <= link_addr;
			// flag comes from the previous accepted instruction
			id_ex_o.is_in_delayslot <= in_delayslot_q;
			id_ex_o.reserved        <= dec.reserved;
			branch_flag_o           <= taken;
			branch_target_o         <= target;
			in_delayslot_q          <= taken;
		end
	end

	stall_holds: assert property (@(posedge clk) disable iff (reset_i)
		stall_i |=> $stable(id_ex_o) && $stable(branch_flag_o)
			&& $stable(branch_target_o) && $stable(in_delayslot_q))
		else $error("id_stage: outputs moved during stall");

	flag_is_jump: assert property (@(posedge clk) disable iff (reset_i)
		branch_flag_o |-> id_ex_o.alusel == SEL_JUMP_BRANCH)
		else $error("id_stage: branch flag on a non-branch instruction");

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
// branch_unit: resolves jump and branch direction, target and link address in decode
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  id_pkg::reg_bus_t inst_i,
	input  id_pkg::reg_bus_t pc_i,
	input  id_pkg::aluop_e   aluop_i,
	input  id_pkg::reg_bus_t reg1_i,
	input  id_pkg::reg_bus_t reg2_i,
	output logic             taken_o,
	output id_pkg::reg_bus_t target_o,
	output id_pkg::reg_bus_t link_addr_o
);
	import id_pkg::*;

	reg_bus_t pc_plus_4;
	reg_bus_t pc_plus_8;
	reg_bus_t br_offset;
	reg_bus_t jump_target;
	reg_bus_t dest;
	logic     reg1_neg;
	logic     reg1_zero;

	assign pc_plus_4   = pc_i + 32'd4;
	assign pc_plus_8   = pc_i + 32'd8;
	assign br_offset   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
	assign reg1_neg    = reg1_i[31];
	assign reg1_zero   = (reg1_i == '0);

	always_comb begin
		taken_o     = 1'b0;
		dest        = pc_plus_4 + br_offset;
		link_addr_o = '0;

		case (aluop_i)
			ALU_J, ALU_JAL: begin
				taken_o = 1'b1;
				dest    = jump_target;
			end
			ALU_JR, ALU_JALR: begin
				taken_o = 1'b1;
				dest    = reg1_i;
			end
			ALU_BEQ:                taken_o = (reg1_i == reg2_i);
			ALU_BNE:                taken_o = (reg1_i != reg2_i);
			ALU_BGTZ:               taken_o = !reg1_neg && !reg1_zero;
			ALU_BLEZ:               taken_o = reg1_neg || reg1_zero;
			ALU_BGEZ, ALU_BGEZAL:   taken_o = !reg1_neg;
			ALU_BLTZ, ALU_BLTZAL:   taken_o = reg1_neg;
			default: ;
		endcase

		// return address skips the delay slot
		case (aluop_i)
			ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL: link_addr_o = pc_plus_8;
			default: ;
		endcase
	end

	assign target_o = taken_o ? dest : '0;

endmodule

`default_nettype wire

// ==== verilog/operand_forward.sv ====
// operand_forward: picks one source operand from EX/MEM bypass, register file or immediate
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
	input  logic              read_i,
	input  id_pkg::reg_addr_t addr_i,
	input  id_pkg::reg_bus_t  rf_data_i,
	input  id_pkg::reg_bus_t  imm_i,
	input  id_pkg::bypass_t   ex_bypass_i,
	input  id_pkg::bypass_t   mem_bypass_i,
	output id_pkg::reg_bus_t  operand_o
);

	logic ex_hit;
	logic mem_hit;

	// r0 is not filtered, later stages never write it
	assign ex_hit  = ex_bypass_i.wreg && (ex_bypass_i.wd == addr_i);
	assign mem_hit = mem_bypass_i.wreg && (mem_bypass_i.wd == addr_i);

	always_comb begin
		if (!read_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_bypass_i.wdata;
		else if (mem_hit)
			operand_o = mem_bypass_i.wdata;
		else
			operand_o = rf_data_i;
	end

	// an unknown bypass tag would fall through to the register file
	always_comb begin
		assert final (!read_i || !$isunknown({ex_hit, mem_hit}))
			else $error("operand_forward: bypass match is unknown on an enabled read");
	end

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
// inst_decoder: turns a MIPS32 instruction word into operation, operand selects and destination
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  id_pkg::reg_bus_t inst_i,
	output id_pkg::decode_t  dec_o
);
	import id_pkg::*;

	logic [5:0]  op;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [4:0]  sa;
	logic [5:0]  funct;
	logic [15:0] imm16;
	logic        shift_imm;
	logic        valid;
	aluop_e      reg_op;
	alusel_e     reg_sel;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign sa    = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	// sll/srl/sra take sa instead of rs
	assign shift_imm = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);

	// SPECIAL function table
	always_comb begin
		case (funct)
			FN_SLL, FN_SLLV: reg_op = ALU_SLL;
			FN_SRL, FN_SRLV: reg_op = ALU_SRL;
			FN_SRA, FN_SRAV: reg_op = ALU_SRA;
			FN_JR:           reg_op = ALU_JR;
			FN_JALR:         reg_op = ALU_JALR;
			FN_ADD:          reg_op = ALU_ADD;
			FN_ADDU:         reg_op = ALU_ADDU;
			FN_SUB:          reg_op = ALU_SUB;
			FN_SUBU:         reg_op = ALU_SUBU;
			FN_AND:          reg_op = ALU_AND;
			FN_OR:           reg_op = ALU_OR;
			FN_XOR:          reg_op = ALU_XOR;
			FN_NOR:          reg_op = ALU_NOR;
			FN_SLT:          reg_op = ALU_SLT;
			FN_SLTU:         reg_op = ALU_SLTU;
			default:         reg_op = ALU_NOP;
		endcase
	end

	always_comb begin
		case (reg_op)
			ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: reg_sel = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:         reg_sel = SEL_SHIFT;
			ALU_JR, ALU_JALR:                  reg_sel = SEL_JUMP_BRANCH;
			ALU_NOP:                           reg_sel = SEL_NOP;
			default:                           reg_sel = SEL_ARITH;
		endcase
	end

	always_comb begin
		dec_o           = '0;
		dec_o.aluop     = ALU_NOP;
		dec_o.alusel    = SEL_NOP;
		dec_o.wd        = rd;
		dec_o.reg1_addr = rs;
		dec_o.reg2_addr = rt;
		valid           = 1'b0;

		case (op)
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
				valid           = 1'b1;
				dec_o.wreg      = 1'b1;
				dec_o.wd        = rt;
				dec_o.alusel    = SEL_LOGIC;
				dec_o.reg1_read = 1'b1;
				dec_o.imm       = {16'h0, imm16};
				case (op)
					OP_ANDI: dec_o.aluop = ALU_AND;
					OP_XORI: dec_o.aluop = ALU_XOR;
					default: dec_o.aluop = ALU_OR;
				endcase
				// lui ors the upper half into rs, which is zero by encoding
				if (op == OP_LUI)
					dec_o.imm = {imm16, 16'h0};
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				valid           = 1'b1;
				dec_o.wreg      = 1'b1;
				dec_o.wd        = rt;
				dec_o.alusel    = SEL_ARITH;
				dec_o.reg1_read = 1'b1;
				dec_o.imm       = {{16{imm16[15]}}, imm16};
				case (op)
					OP_ADDI:  dec_o.aluop = ALU_ADDI;
					OP_ADDIU: dec_o.aluop = ALU_ADDIU;
					OP_SLTI:  dec_o.aluop = ALU_SLT;
					default:  dec_o.aluop = ALU_SLTU;
				endcase
			end
			OP_J, OP_JAL: begin
				valid        = 1'b1;
				dec_o.alusel = SEL_JUMP_BRANCH;
				dec_o.aluop  = (op == OP_JAL) ? ALU_JAL : ALU_J;
				if (op == OP_JAL) begin
					dec_o.wreg = 1'b1;
					dec_o.wd   = REG_RA;
				end
			end
			OP_BEQ, OP_BNE: begin
				valid           = 1'b1;
				dec_o.alusel    = SEL_JUMP_BRANCH;
				dec_o.aluop     = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				dec_o.reg1_read = 1'b1;
				dec_o.reg2_read = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: begin
				valid           = 1'b1;
				dec_o.alusel    = SEL_JUMP_BRANCH;
				dec_o.aluop     = (op == OP_BLEZ) ? ALU_BLEZ : ALU_BGTZ;
				dec_o.reg1_read = 1'b1;
			end
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ: begin
						valid       = 1'b1;
						dec_o.aluop = ALU_BLTZ;
					end
					RT_BGEZ: begin
						valid       = 1'b1;
						dec_o.aluop = ALU_BGEZ;
					end
					RT_BLTZAL, RT_BGEZAL: begin
						valid       = 1'b1;
						dec_o.aluop = (rt == RT_BLTZAL) ? ALU_BLTZAL : ALU_BGEZAL;
						// link is written taken or not
						dec_o.wreg  = 1'b1;
						dec_o.wd    = REG_RA;
					end
					default: ;
				endcase
				if (valid) begin
					dec_o.alusel    = SEL_JUMP_BRANCH;
					dec_o.reg1_read = 1'b1;
				end
			end
			OP_SPECIAL: begin
				if (reg_op != ALU_NOP && (shift_imm ? rs == 5'd0 : sa == 5'd0)) begin
					valid           = 1'b1;
					dec_o.aluop     = reg_op;
					dec_o.alusel    = reg_sel;
					dec_o.wreg      = (reg_op != ALU_JR);
					dec_o.reg1_read = !shift_imm;
					dec_o.reg2_read = (reg_sel != SEL_JUMP_BRANCH);
					// shift amount goes out as operand 1
					dec_o.imm       = shift_imm ? {27'h0, sa} : '0;
				end
			end
			default: ;
		endcase

		dec_o.reserved = !valid;
	end

	always_comb begin
		assert final (!dec_o.reserved || !dec_o.wreg)
			else $error("inst_decoder: reserved encoding %h requests a write", inst_i);
	end

endmodule

`default_nettype wire

// ==== verilog/id_pkg.sv ====
// id_pkg: shared widths, encodings and structs for the MIPS32 decode stage
`default_nettype none

package id_pkg;

	localparam int REG_WIDTH      = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int ALUOP_WIDTH    = 6;
	localparam int ALUSEL_WIDTH   = 3;

	typedef logic [REG_WIDTH-1:0]      reg_bus_t;
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

	// link register
	localparam reg_addr_t REG_RA = 5'd31;

	typedef enum logic [ALUOP_WIDTH-1:0] {
		ALU_NOP    = 6'd0,
		ALU_OR     = 6'd1,
		ALU_AND    = 6'd2,
		ALU_XOR    = 6'd3,
		ALU_NOR    = 6'd4,
		ALU_SLL    = 6'd5,
		ALU_SRL    = 6'd6,
		ALU_SRA    = 6'd7,
		ALU_ADD    = 6'd8,
		ALU_ADDU   = 6'd9,
		ALU_ADDI   = 6'd10,
		ALU_ADDIU  = 6'd11,
		ALU_SUB    = 6'd12,
		ALU_SUBU   = 6'd13,
		ALU_SLT    = 6'd14,
		ALU_SLTU   = 6'd15,
		ALU_J      = 6'd16,
		ALU_JAL    = 6'd17,
		ALU_JR     = 6'd18,
		ALU_JALR   = 6'd19,
		ALU_BEQ    = 6'd20,
		ALU_BNE    = 6'd21,
		ALU_BGTZ   = 6'd22,
		ALU_BLEZ   = 6'd23,
		ALU_BGEZ   = 6'd24,
		ALU_BGEZAL = 6'd25,
		ALU_BLTZ   = 6'd26,
		ALU_BLTZAL = 6'd27
	} aluop_e;

	typedef enum logic [ALUSEL_WIDTH-1:0] {
		SEL_NOP         = 3'd0,
		SEL_LOGIC       = 3'd1,
		SEL_SHIFT       = 3'd2,
		SEL_ARITH       = 3'd3,
		SEL_JUMP_BRANCH = 3'd4
	} alusel_e;

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// SPECIAL function codes, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM rt codes, inst[20:16]
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		logic      wreg;
		reg_addr_t wd;
		logic      reg1_read;
		logic      reg2_read;
		reg_addr_t reg1_addr;
		reg_addr_t reg2_addr;
		reg_bus_t  imm;
		logic      reserved;
	} decode_t;

	// write-back bypass from a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		reg_bus_t  wdata;
	} bypass_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		reg_bus_t  reg1;
		reg_bus_t  reg2;
		reg_addr_t wd;
		logic      wreg;
		reg_bus_t  link_addr;
		logic      is_in_delayslot;
		logic      reserved;
	} id_ex_t;

endpackage

`default_nettype wire
